// ==== decodeStage.sv ====
/*
 * Decode stage: IF/ID register, field extraction, immediate extension
 */
`timescale 1ns/1ps
`include "rvSettings.svh"

module decodeStage import rvPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                stallD_i,
    input  logic                flushD_i,
    input  logic [`RV_XLEN-1:0] instrF_i,
    input  logic [`RV_XLEN-1:0] pcF_i,
    input  logic [`RV_XLEN-1:0] pcPlus4F_i,
    input  decodeCtrl_t         decodeCtrl_i,
    output decodeInfo_t         decodeInfo_o,
    output logic [`RV_XLEN-1:0] pcD_o,
    output logic [`RV_XLEN-1:0] pcPlus4D_o,
    output logic [`RV_XLEN-1:0] extImmD_o
);

    instrWord_u instrD;

    // Flush turns the slot into an all-zero bubble
    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD     <= '0;
            pcD_o      <= '0;
            pcPlus4D_o <= '0;
        end else if (!stallD_i) begin
            instrD     <= instrF_i;
            pcD_o      <= pcF_i;
            pcPlus4D_o <= pcPlus4F_i;
        end
    end

    assign decodeInfo_o.opcode   = instrD.rFields.opcode;
    assign decodeInfo_o.funct3   = instrD.rFields.funct3;
    assign decodeInfo_o.funct7b5 = instrD.rFields.funct7[5];
    assign decodeInfo_o.rs1      = instrD.rFields.rs1;
    assign decodeInfo_o.rs2      = instrD.rFields.rs2;
    assign decodeInfo_o.rd       = instrD.rFields.rd;

    always_comb begin
        unique case (decodeCtrl_i.immSrc)
            IMM_I: extImmD_o = {{20{instrD.iFields.imm12[11]}}, instrD.iFields.imm12};
            IMM_S: extImmD_o = {{20{instrD.sFields.immHi[6]}},
                                instrD.sFields.immHi, instrD.sFields.immLo};
            IMM_B: extImmD_o = {{20{instrD.bFields.sign}}, instrD.bFields.imm11,
                                instrD.bFields.imm10to5, instrD.bFields.imm4to1, 1'b0};
            // J immediate is scattered over the upper 20 bits
            IMM_J: extImmD_o = {{12{instrD.rFields.funct7[6]}},
                                instrD.rFields.rs1, instrD.rFields.funct3,
                                instrD.rFields.rs2[0],
                                instrD.rFields.funct7[5:0], instrD.rFields.rs2[4:1], 1'b0};
            IMM_U: extImmD_o = {instrD.rFields.funct7, instrD.rFields.rs2,
                                instrD.rFields.rs1, instrD.rFields.funct3, 12'b0};
            default: extImmD_o = '0;
        endcase
    end

endmodule

// ==== executeStage.sv ====
/*
 * Execute stage: ID/EX register, operand forwarding and source select,
 * ALU and branch target adder
 */
`timescale 1ns/1ps
`include "rvSettings.svh"

module executeStage import rvPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                flushE_i,
    input  exCtrl_t             exCtrl_i,
    input  decodeInfo_t         decodeInfo_i,
    input  logic [`RV_XLEN-1:0] pcD_i,
    input  logic [`RV_XLEN-1:0] pcPlus4D_i,
    input  logic [`RV_XLEN-1:0] extImmD_i,
    input  logic [`RV_XLEN-1:0] rd1D_i,
    input  logic [`RV_XLEN-1:0] rd2D_i,
    input  logic [`RV_XLEN-1:0] forwardDataM_i,
    input  logic [`RV_XLEN-1:0] resultW_i,
    output exStage_t            exStage_o,
    output logic                zeroE_o,
    output logic [`RV_XLEN-1:0] pcTargetE_o,
    output memStage_t           memNext_o
);

    logic [`RV_XLEN-1:0] srcAE;
    logic [`RV_XLEN-1:0] srcBE;
    logic [`RV_XLEN-1:0] writeDataE;
    logic [`RV_XLEN-1:0] aluResultE;

    function automatic logic [`RV_XLEN-1:0] fwdSelect(
        input forward_e            sel,
        input logic [`RV_XLEN-1:0] regVal
    );
        unique case (sel)
            FWD_WB:  return resultW_i;
            FWD_MEM: return forwardDataM_i;
            default: return regVal; // FWD_EX
        endcase
    endfunction

    // No stall here; a flush inserts a bubble
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            exStage_o <= '0;
        end else begin
            exStage_o <= '{
                rd1:     rd1D_i,
                rd2:     rd2D_i,
                pc:      pcD_i,
                extImm:  extImmD_i,
                pcPlus4: pcPlus4D_i,
                rs1:     decodeInfo_i.rs1,
                rs2:     decodeInfo_i.rs2,
                rd:      decodeInfo_i.rd
            };
        end
    end

    assign srcAE      = fwdSelect(exCtrl_i.forwardA, exStage_o.rd1);
    assign writeDataE = fwdSelect(exCtrl_i.forwardB, exStage_o.rd2);
    assign srcBE      = (exCtrl_i.aluSrc == SRCB_IMM) ? exStage_o.extImm : writeDataE;

    always_comb begin
        unique case (exCtrl_i.aluControl)
            ALU_ADD: aluResultE = srcAE + srcBE;
            ALU_SUB: aluResultE = srcAE - srcBE;
            ALU_AND: aluResultE = srcAE & srcBE;
            ALU_OR:  aluResultE = srcAE | srcBE;
            ALU_SLT: aluResultE = {{(`RV_XLEN-1){1'b0}}, $signed(srcAE) < $signed(srcBE)};
            default: aluResultE = '0;
        endcase
    end

    assign zeroE_o     = (aluResultE == '0);
    assign pcTargetE_o = exStage_o.pc + exStage_o.extImm; // Branch and JAL target

    assign memNext_o.aluResult = aluResultE;
    assign memNext_o.writeData = writeDataE;
    assign memNext_o.extImm    = exStage_o.extImm;
    assign memNext_o.pcPlus4   = exStage_o.pcPlus4;
    assign memNext_o.rd        = exStage_o.rd;

    // Hazard unit must never drive the spare forward code
    assertFwdLegal: assert property (@(posedge clk) disable iff (reset)
        (exCtrl_i.forwardA inside {FWD_EX, FWD_WB, FWD_MEM}) &&
        (exCtrl_i.forwardB inside {FWD_EX, FWD_WB, FWD_MEM}))
        else $error("illegal forward select in execute");

endmodule

// ==== fetchStage.sv ====
/*
 * Fetch stage: PC register with stall and branch redirect, PC+4 adder
 */
`timescale 1ns/1ps
`include "rvSettings.svh"

module fetchStage (
    input  logic               clk,
    input  logic               reset,
    input  logic               stallF_i,
    input  logic               pcSrcE_i,
    input  logic [`RV_XLEN-1:0] pcTargetE_i,
    output logic [`RV_XLEN-1:0] pcF_o,
    output logic [`RV_XLEN-1:0] pcPlus4F_o
);

    assign pcPlus4F_o = pcF_o + 'd4;

    // A taken branch in execute overrides a fetch stall
    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= `RV_PC_START;
        end else if (pcSrcE_i) begin
            pcF_o <= pcTargetE_i;
        end else if (!stallF_i) begin
            pcF_o <= pcPlus4F_o;
        end
    end

endmodule

// ==== memWbStage.sv ====
/*
 * Memory and writeback stages: EX/MEM and MEM/WB registers,
 * memory forward data select and writeback result mux
 */
`timescale 1ns/1ps
`include "rvSettings.svh"

module memWbStage import rvPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  memStage_t             memNext_i,
    input  logic [`RV_XLEN-1:0]   readDataM_i,
    input  wbCtrl_t               wbCtrl_i,
    output memStage_t             memStage_o,
    output logic [`RV_XLEN-1:0]   forwardDataM_o,
    output logic [`RV_XLEN-1:0]   resultW_o,
    output logic [`RV_REG_AW-1:0] rdW_o,
    output logic                  regWriteW_o
);

    logic [`RV_XLEN-1:0] aluResultW;
    logic [`RV_XLEN-1:0] readDataW;
    logic [`RV_XLEN-1:0] extImmW;
    logic [`RV_XLEN-1:0] pcPlus4W;

    always_ff @(posedge clk) begin
        if (reset) begin
            memStage_o <= '0;
            aluResultW <= '0;
            readDataW  <= '0;
            extImmW    <= '0;
            pcPlus4W   <= '0;
            rdW_o      <= '0;
        end else begin
            memStage_o <= memNext_i;
            aluResultW <= memStage_o.aluResult;
            readDataW  <= readDataM_i;
            extImmW    <= memStage_o.extImm;
            pcPlus4W   <= memStage_o.pcPlus4;
            rdW_o      <= memStage_o.rd;
        end
    end

    // Load data is not available yet, so RES_MEM falls back to the ALU value
    always_comb begin
        unique case (wbCtrl_i.resultSrcM)
            RES_PC4: forwardDataM_o = memStage_o.pcPlus4;
            RES_IMM: forwardDataM_o = memStage_o.extImm;
            default: forwardDataM_o = memStage_o.aluResult;
        endcase
    end

    always_comb begin
        unique case (wbCtrl_i.resultSrcW)
            RES_MEM: resultW_o = readDataW;
            RES_ALU: resultW_o = aluResultW;
            RES_PC4: resultW_o = pcPlus4W;
            RES_IMM: resultW_o = extImmW;
            default: resultW_o = aluResultW;
        endcase
    end

    assign regWriteW_o = wbCtrl_i.regWriteW;

endmodule

// ==== regFile.sv ====
/*
 * Register file, two read ports and one write port, x0 tied to zero
 */
`timescale 1ns/1ps
`include "rvSettings.svh"

module regFile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`RV_REG_AW-1:0] rs1_i,
    input  logic [`RV_REG_AW-1:0] rs2_i,
    input  logic [`RV_REG_AW-1:0] rd_i,
    input  logic                  we_i,
    input  logic [`RV_XLEN-1:0]   wd_i,
    output logic [`RV_XLEN-1:0]   rd1_o,
    output logic [`RV_XLEN-1:0]   rd2_o
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];
    logic                wrActive;

    assign wrActive = we_i && !reset && (rd_i != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            regs[0] <= '0; // x0 is cleared here and never written
        end else if (wrActive) begin
            regs[rd_i] <= wd_i;
        end
    end

    // Same-cycle write is visible on the read ports
    assign rd1_o = (wrActive && rd_i == rs1_i) ? wd_i : regs[rs1_i];
    assign rd2_o = (wrActive && rd_i == rs2_i) ? wd_i : regs[rs2_i];

    assertX0Zero: assert property (@(posedge clk) disable iff (reset)
        (we_i && rd_i == '0) |=> ((rs1_i != '0) || (rd1_o == '0)) &&
                                 ((rs2_i != '0) || (rd2_o == '0)))
        else $error("x0 read back nonzero after a write to x0");

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the datapath testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rvDatapath.f --top-module tb_rvDatapath
./obj_dir/Vtb_rvDatapath | tee sim.log

if grep -qx "TEST OK" sim.log; then
    exit 0
fi
exit 1

// ==== rvDatapath.f ====
+incdir+.
rvPkg.sv
fetchStage.sv
decodeStage.sv
regFile.sv
executeStage.sv
memWbStage.sv
rvDatapath.sv
tb_rvDatapath.sv

// ==== rvDatapath.sv ====
/*
 * Top of the five-stage RV32 datapath, stages and register file wired together
 */
`timescale 1ns/1ps
`include "rvSettings.svh"

module rvDatapath import rvPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stallF_i,
    input  logic                  stallD_i,
    input  logic                  flushD_i,
    input  logic                  flushE_i,
    input  logic                  pcSrcE_i,
    input  logic [`RV_XLEN-1:0]   instrF_i,
    input  logic [`RV_XLEN-1:0]   readDataM_i,
    input  decodeCtrl_t           decodeCtrl_i,
    input  exCtrl_t               exCtrl_i,
    input  wbCtrl_t               wbCtrl_i,
    output logic [`RV_XLEN-1:0]   pcF_o,
    output decodeInfo_t           decodeInfo_o,
    output logic [`RV_REG_AW-1:0] rs1E_o,
    output logic [`RV_REG_AW-1:0] rs2E_o,
    output logic [`RV_REG_AW-1:0] rdE_o,
    output logic                  zeroE_o,
    output logic [`RV_REG_AW-1:0] rdM_o,
    output logic [`RV_XLEN-1:0]   aluResultM_o,
    output logic [`RV_XLEN-1:0]   writeDataM_o,
    output logic [`RV_REG_AW-1:0] rdW_o
);

    logic [`RV_XLEN-1:0] pcPlus4F, pcD, pcPlus4D, extImmD;
    logic [`RV_XLEN-1:0] rd1D, rd2D, pcTargetE;
    logic [`RV_XLEN-1:0] forwardDataM, resultW;
    logic                regWriteW;
    exStage_t            exStage;
    memStage_t           memNext, memStage;

    fetchStage fetch_i (
        .clk, .reset, .stallF_i, .pcSrcE_i,
        .pcTargetE_i (pcTargetE),
        .pcF_o, .pcPlus4F_o (pcPlus4F)
    );

    decodeStage decode_i (
        .clk, .reset, .stallD_i, .flushD_i, .instrF_i,
        .pcF_i (pcF_o), .pcPlus4F_i (pcPlus4F), .decodeCtrl_i,
        .decodeInfo_o, .pcD_o (pcD), .pcPlus4D_o (pcPlus4D), .extImmD_o (extImmD)
    );

    regFile regFile_i (
        .clk, .reset,
        .rs1_i (decodeInfo_o.rs1), .rs2_i (decodeInfo_o.rs2),
        .rd_i (rdW_o), .we_i (regWriteW), .wd_i (resultW),
        .rd1_o (rd1D), .rd2_o (rd2D)
    );

    executeStage execute_i (
        .clk, .reset, .flushE_i, .exCtrl_i, .decodeInfo_i (decodeInfo_o),
        .pcD_i (pcD), .pcPlus4D_i (pcPlus4D), .extImmD_i (extImmD),
        .rd1D_i (rd1D), .rd2D_i (rd2D),
        .forwardDataM_i (forwardDataM), .resultW_i (resultW),
        .exStage_o (exStage), .zeroE_o, .pcTargetE_o (pcTargetE), .memNext_o (memNext)
    );

    memWbStage memWb_i (
        .clk, .reset, .memNext_i (memNext), .readDataM_i, .wbCtrl_i,
        .memStage_o (memStage), .forwardDataM_o (forwardDataM),
        .resultW_o (resultW), .rdW_o, .regWriteW_o (regWriteW)
    );

    assign rs1E_o       = exStage.rs1;
    assign rs2E_o       = exStage.rs2;
    assign rdE_o        = exStage.rd;
    assign rdM_o        = memStage.rd;
    assign aluResultM_o = memStage.aluResult;
    assign writeDataM_o = memStage.writeData; // Store data after forwarding

endmodule

// ==== rvPkg.sv ====
/*
 * Control encodings, instruction word union and pipeline stage structs
 */
package rvPkg;
    `include "rvSettings.svh"

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_J = 3'd3,
        IMM_U = 3'd4
    } immSrc_e;

    // 2'b11 is not a legal operand source
    typedef enum logic [1:0] {
        FWD_EX  = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } forward_e;

    typedef enum logic {
        SRCB_REG = 1'b0,
        SRCB_IMM = 1'b1
    } aluSrc_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } aluControl_e;

    typedef enum logic [1:0] {
        RES_MEM = 2'b00,
        RES_ALU = 2'b01,
        RES_PC4 = 2'b10,
        RES_IMM = 2'b11
    } resultSrc_e;

    // One 32-bit word seen through the R, I, S and B layouts
    typedef union packed {
        struct packed {
            logic [6:0]           funct7;
            logic [`RV_REG_AW-1:0] rs2;
            logic [`RV_REG_AW-1:0] rs1;
            logic [2:0]           funct3;
            logic [`RV_REG_AW-1:0] rd;
            logic [6:0]           opcode;
        } rFields;
        struct packed {
            logic [11:0]          imm12;
            logic [`RV_REG_AW-1:0] rs1;
            logic [2:0]           funct3;
            logic [`RV_REG_AW-1:0] rd;
            logic [6:0]           opcode;
        } iFields;
        struct packed {
            logic [6:0]           immHi;
            logic [`RV_REG_AW-1:0] rs2;
            logic [`RV_REG_AW-1:0] rs1;
            logic [2:0]           funct3;
            logic [4:0]           immLo;
            logic [6:0]           opcode;
        } sFields;
        struct packed {
            logic                 sign;     // imm[12]
            logic [5:0]           imm10to5;
            logic [`RV_REG_AW-1:0] rs2;
            logic [`RV_REG_AW-1:0] rs1;
            logic [2:0]           funct3;
            logic [3:0]           imm4to1;
            logic                 imm11;
            logic [6:0]           opcode;
        } bFields;
    } instrWord_u;

    typedef struct packed {
        logic [6:0]           opcode;
        logic [2:0]           funct3;
        logic                 funct7b5;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
    } decodeInfo_t;

    typedef struct packed {
        immSrc_e immSrc;
    } decodeCtrl_t;

    typedef struct packed {
        aluSrc_e     aluSrc;
        aluControl_e aluControl;
        forward_e    forwardA;
        forward_e    forwardB;
    } exCtrl_t;

    typedef struct packed {
        resultSrc_e resultSrcM;
        resultSrc_e resultSrcW;
        logic       regWriteW;
    } wbCtrl_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   rd1;
        logic [`RV_XLEN-1:0]   rd2;
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   extImm;
        logic [`RV_XLEN-1:0]   pcPlus4;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
    } exStage_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   aluResult;
        logic [`RV_XLEN-1:0]   writeData;
        logic [`RV_XLEN-1:0]   extImm;
        logic [`RV_XLEN-1:0]   pcPlus4;
        logic [`RV_REG_AW-1:0] rd;
    } memStage_t;

endpackage

// ==== rvSettings.svh ====
/*
 * Global sizing macros for the RV32 datapath
 * Data width, register file geometry and reset PC
 */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`define RV_XLEN      32
`define RV_REG_AW    5
`define RV_NUM_REGS  32

// First fetch address after reset
`define RV_PC_START  32'h0000_1000

`endif

// ==== tb_rvDatapath.sv ====
/*
 * Testbench for the RV32 datapath with random stimulus
 * checked against a pipeline, PC and register file model
 */
`timescale 1ns/1ps
`include "rvSettings.svh"

module tb_rvDatapath import rvPkg::*; ();

    localparam int MODE_IDLE   = 0;
    localparam int MODE_PC     = 1;
    localparam int MODE_IMM    = 2;
    localparam int MODE_FWD    = 3;
    localparam int MODE_WB     = 4;
    localparam int MODE_FLUSH  = 5;
    localparam int DRAIN_LIMIT = 10;

    // One instruction as the model follows it down the pipeline
    typedef struct packed {
        logic [`RV_XLEN-1:0] word;
        immSrc_e             immSrc;
        aluSrc_e             aluSrc;
        aluControl_e         aluCtl;
        forward_e            fwdA;
        forward_e            fwdB;
        resultSrc_e          resSrcM;
        resultSrc_e          resSrcW;
        logic                regWrite;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] pcPlus4;
        logic [`RV_XLEN-1:0] rd1;
        logic [`RV_XLEN-1:0] rd2;
        logic [`RV_XLEN-1:0] aluResult;
        logic [`RV_XLEN-1:0] writeData;
        logic [`RV_XLEN-1:0] readData;
    } modelOp_t;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  stallF_i, stallD_i, flushD_i, flushE_i, pcSrcE_i;
    logic [`RV_XLEN-1:0]   instrF_i, readDataM_i;
    decodeCtrl_t           decodeCtrl_i;
    exCtrl_t               exCtrl_i;
    wbCtrl_t               wbCtrl_i;
    logic [`RV_XLEN-1:0]   pcF_o, aluResultM_o, writeDataM_o;
    decodeInfo_t           decodeInfo_o;
    logic [`RV_REG_AW-1:0] rs1E_o, rs2E_o, rdE_o, rdM_o, rdW_o;
    logic                  zeroE_o;

    modelOp_t              opD, opE, opM, opW;
    logic [`RV_XLEN-1:0]   pcModel;
    logic [`RV_XLEN-1:0]   shadow [`RV_NUM_REGS];
    logic                  known [`RV_NUM_REGS];   // Registers written since reset
    int                    errorCount = 0;
    int                    checkCount = 0;
    logic                  timedOut = 1'b0;
    logic                  pipeBusy;

    rvDatapath dut_i (.*);

    always #20 clk = ~clk;

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Immediate layouts of the RISC-V base ISA
    function automatic logic [31:0] immOf(input modelOp_t op);
        logic [31:0] w;
        w = op.word;
        case (op.immSrc)
            IMM_I:   return {{20{w[31]}}, w[31:20]};
            IMM_S:   return {{20{w[31]}}, w[31:25], w[11:7]};
            IMM_B:   return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            IMM_J:   return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            IMM_U:   return {w[31:12], 12'b0};
            default: return '0;
        endcase
    endfunction

    function automatic logic [31:0] wbResult(input modelOp_t op);
        case (op.resSrcW)
            RES_MEM: return op.readData;
            RES_PC4: return op.pcPlus4;
            RES_IMM: return immOf(op);
            default: return op.aluResult;
        endcase
    endfunction

    function automatic logic [31:0] memForward(input modelOp_t op);
        case (op.resSrcM)
            RES_PC4: return op.pcPlus4;
            RES_IMM: return immOf(op);
            default: return op.aluResult;   // Load data is not back yet
        endcase
    endfunction

    function automatic logic [31:0] operand(input forward_e sel, input logic [31:0] regVal,
                                            input modelOp_t m, input modelOp_t w);
        case (sel)
            FWD_WB:  return wbResult(w);
            FWD_MEM: return memForward(m);
            default: return regVal;
        endcase
    endfunction

    function automatic logic [31:0] aluModel(input aluControl_e ctl, input logic [31:0] a,
                                             input logic [31:0] b);
        case (ctl)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    function automatic modelOp_t executeOp(input modelOp_t e, input modelOp_t m,
                                           input modelOp_t w);
        modelOp_t res;
        logic [31:0] srcA;
        logic [31:0] srcB;
        res  = e;
        srcA = operand(e.fwdA, e.rd1, m, w);
        res.writeData = operand(e.fwdB, e.rd2, m, w);
        srcB = (e.aluSrc == SRCB_IMM) ? immOf(e) : res.writeData;
        res.aluResult = aluModel(e.aluCtl, srcA, srcB);
        return res;
    endfunction

    function automatic logic [31:0] readReg(input logic [4:0] r);
        return (r == 5'd0) ? 32'd0 : shadow[r];
    endfunction

    function automatic logic [4:0] pickKnown();
        logic [4:0] r;
        int i;
        for (i = 0; i < 16; i++) begin
            r = 5'($urandom_range(0, 31));
            if (known[r]) return r;
        end
        return 5'd0;
    endfunction

    function automatic aluControl_e randAlu();
        case ($urandom_range(0, 4))
            0:       return ALU_ADD;
            1:       return ALU_SUB;
            2:       return ALU_AND;
            3:       return ALU_OR;
            default: return ALU_SLT;
        endcase
    endfunction

    function automatic modelOp_t makeOp(input int mode);
        modelOp_t op;
        logic [31:0] w;
        logic [4:0] rd;
        op = '0;
        if (mode == MODE_IDLE) return op;   // All-zero bubble
        w = $urandom;
        w[19:15] = pickKnown();
        w[24:20] = pickKnown();
        rd = 5'($urandom_range(1, 31));
        op.aluCtl = randAlu();
        op.aluSrc = aluSrc_e'(1'($urandom_range(0, 1)));
        case (mode)
            MODE_PC: op.immSrc = IMM_B;
            MODE_IMM: begin
                op.immSrc   = IMM_I;
                op.aluSrc   = SRCB_IMM;
                op.regWrite = 1'b1;
                op.resSrcM  = RES_ALU;
                op.resSrcW  = RES_ALU;
            end
            MODE_WB: begin
                op.immSrc   = IMM_I;
                op.regWrite = 1'b1;
                op.resSrcM  = RES_ALU;
                op.resSrcW  = RES_ALU;
                if ($urandom_range(0, 3) == 0) rd = 5'd0; // Some writes aim at x0
            end
            default: begin
                op.immSrc   = immSrc_e'(3'($urandom_range(0, 4)));
                op.fwdA     = forward_e'(2'($urandom_range(0, 2)));
                op.fwdB     = forward_e'(2'($urandom_range(0, 2)));
                op.resSrcM  = resultSrc_e'(2'($urandom_range(0, 3)));
                op.resSrcW  = resultSrc_e'(2'($urandom_range(0, 3)));
                op.regWrite = 1'($urandom_range(0, 1));
            end
        endcase
        w[11:7] = rd;
        op.word = w;
        return op;
    endfunction

    // What the DUT does at one rising edge
    task automatic advanceModel(input modelOp_t fetchOp, input logic stallF,
                                input logic stallD, input logic pcSrc,
                                input logic flushD, input logic flushE);
        modelOp_t exOut;
        modelOp_t decOut;
        logic [31:0] target;
        exOut  = executeOp(opE, opM, opW);
        target = opE.pc + immOf(opE);
        // Write lands before decode reads, like the register file bypass
        if (opW.regWrite && opW.word[11:7] != 5'd0) begin
            shadow[opW.word[11:7]] = wbResult(opW);
            known[opW.word[11:7]]  = 1'b1;
        end
        decOut     = opD;
        decOut.rd1 = readReg(opD.word[19:15]);
        decOut.rd2 = readReg(opD.word[24:20]);
        opW = opM;
        opM = exOut;
        if (flushE) opE = '0;
        else opE = decOut;
        if (flushD) begin
            opD = '0;
        end else if (!stallD) begin
            opD         = fetchOp;
            opD.pc      = pcModel;
            opD.pcPlus4 = pcModel + 32'd4;
        end
        if (pcSrc) pcModel = target;            // Redirect beats stall
        else if (!stallF) pcModel = pcModel + 32'd4;
    endtask

    task automatic runCycle(input int mode);
        modelOp_t fetchOp;
        modelOp_t exNow;
        logic stallF, stallD, pcSrc, flushD, flushE;
        logic [31:0] rdData;
        fetchOp = makeOp(mode);
        stallF  = (mode == MODE_PC) && ($urandom_range(0, 2) == 0);
        stallD  = (mode == MODE_PC) && ($urandom_range(0, 2) == 0);
        pcSrc   = (mode == MODE_PC) && ($urandom_range(0, 4) == 0);
        flushD  = (mode == MODE_FLUSH) && ($urandom_range(0, 3) == 0);
        flushE  = (mode == MODE_FLUSH) && ($urandom_range(0, 3) == 0);
        rdData  = $urandom;
        opM.readData = rdData;
        instrF_i     <= fetchOp.word;
        readDataM_i  <= rdData;
        stallF_i     <= stallF;
        stallD_i     <= stallD;
        pcSrcE_i     <= pcSrc;
        flushD_i     <= flushD;
        flushE_i     <= flushE;
        decodeCtrl_i <= '{immSrc: opD.immSrc};
        exCtrl_i     <= '{aluSrc: opE.aluSrc, aluControl: opE.aluCtl,
                          forwardA: opE.fwdA, forwardB: opE.fwdB};
        wbCtrl_i     <= '{resultSrcM: opM.resSrcM, resultSrcW: opW.resSrcW,
                          regWriteW: opW.regWrite};
        @(negedge clk);
        exNow = executeOp(opE, opM, opW);
        compare(pcF_o, pcModel, "pcF");
        compare(32'(decodeInfo_o), {6'd0, opD.word[6:0], opD.word[14:12], opD.word[30],
                opD.word[19:15], opD.word[24:20], opD.word[11:7]}, "decodeInfo");
        compare(32'(rs1E_o), 32'(opE.word[19:15]), "rs1E");
        compare(32'(rs2E_o), 32'(opE.word[24:20]), "rs2E");
        compare(32'(rdE_o), 32'(opE.word[11:7]), "rdE");
        compare(32'(zeroE_o), 32'(exNow.aluResult == '0), "zeroE");
        compare(32'(rdM_o), 32'(opM.word[11:7]), "rdM");
        compare(aluResultM_o, opM.aluResult, "aluResultM");
        compare(writeDataM_o, opM.writeData, "writeDataM");
        compare(32'(rdW_o), 32'(opW.word[11:7]), "rdW");
        pipeBusy = (rdE_o != '0) || (rdM_o != '0) || (rdW_o != '0);
        @(posedge clk);
        advanceModel(fetchOp, stallF, stallD, pcSrc, flushD, flushE);
    endtask

    // Feed bubbles until no destination is left in flight
    task automatic drainPipe();
        int waited;
        waited   = 0;
        pipeBusy = 1'b1;
        while (pipeBusy && waited < DRAIN_LIMIT) begin
            runCycle(MODE_IDLE);
            waited++;
        end
        if (pipeBusy) begin
            timedOut = 1'b1;
            $display("timeout: pipeline still busy after %0d idle cycles", waited);
        end
    endtask

    task automatic runPhase(input int id, input string name, input int mode, input int cycles);
        int errStart;
        errStart = errorCount;
        if (timedOut) return;
        repeat (cycles) runCycle(mode);
        drainPipe();
        $display("test %0d %s finished with %0d errors", id, name, errorCount - errStart);
    endtask

    initial begin
        int errStart;
        void'($urandom(34376));
        reset        <= 1'b1;
        stallF_i     <= 1'b0;
        stallD_i     <= 1'b0;
        flushD_i     <= 1'b0;
        flushE_i     <= 1'b0;
        pcSrcE_i     <= 1'b0;
        instrF_i     <= '0;
        readDataM_i  <= '0;
        decodeCtrl_i <= '0;
        exCtrl_i     <= '0;
        wbCtrl_i     <= '0;
        foreach (shadow[i]) begin
            shadow[i] = '0;
            known[i]  = (i == 0);
        end
        opD = '0;
        opE = '0;
        opM = '0;
        opW = '0;
        pcModel = `RV_PC_START;

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        errStart = errorCount;
        compare(pcF_o, `RV_PC_START, "pcF after reset");
        compare(32'(rdE_o), 32'd0, "rdE after reset");
        compare(32'(rdM_o), 32'd0, "rdM after reset");
        compare(32'(rdW_o), 32'd0, "rdW after reset");
        compare(aluResultM_o, 32'd0, "aluResultM after reset");
        $display("test 1 reset values finished with %0d errors", errorCount - errStart);
        @(posedge clk);
        advanceModel('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);

        runPhase(2, "PC sequencing", MODE_PC, 40);
        runPhase(3, "immediate ALU ops", MODE_IMM, 40);
        runPhase(4, "forwarding", MODE_FWD, 60);
        runPhase(5, "register writeback", MODE_WB, 40);
        runPhase(6, "flush", MODE_FLUSH, 60);

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
